/* logic/music_pkg.sv */
package music_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int SONG_LEN   = 48;
    localparam int IDX_W      = 6;
    localparam int NOTE_W     = 8;
    localparam int DUR_W      = 8;
    localparam int TEMPO_W    = 16;  // clk_out cycles per step
    localparam int PER_W      = 24;
    localparam int AXI_ADDR_W = 4;
    localparam int AXI_DATA_W = 32;

    localparam logic [TEMPO_W-1:0] TEMPO_RESET = 16'd4;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Octave-zero half-periods, C upward, equal tempered
    localparam logic [PER_W-1:0] PITCH_HALF [12] = '{
        24'd1600, 24'd1510, 24'd1425, 24'd1345,
        24'd1270, 24'd1199, 24'd1131, 24'd1068,
        24'd1008, 24'd951,  24'd898,  24'd848
    };

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_PLAY
    } player_state_t;

    typedef enum logic [AXI_ADDR_W-1:0] {
        REG_CTRL   = 4'h0,  // 0 start, 1 stop, 2 loop
        REG_TEMPO  = 4'h4,
        REG_STATUS = 4'h8,  // 0 playing, 13:8 index
        REG_NOTE   = 4'hC
    } reg_addr_t;

endpackage

/* logic/player_ctrl_if.sv */
`timescale 1ns/1ps

interface player_ctrl_if;
    // Host side
    logic                         start;  // One-cycle pulse
    logic                         stop;   // One-cycle pulse
    logic                         loop;
    logic [music_pkg::TEMPO_W-1:0] tempo;

    // Sequencer side
    logic                         playing;
    logic [music_pkg::IDX_W-1:0]   index;
    logic [music_pkg::NOTE_W-1:0]  note;

    modport regs (output start, stop, loop, tempo, input playing, index, note);
    modport seq (input start, stop, loop, tempo, output playing, index, note);
endinterface

/* logic/note_timer_if.sv */
`timescale 1ns/1ps

interface note_timer_if;
    logic                         load;      // Restarts the timer
    logic [music_pkg::DUR_W-1:0]   duration;  // In steps
    logic [music_pkg::TEMPO_W-1:0] tempo;     // Cycles per step
    logic                         expire;

    modport seq (output load, duration, tempo, input expire);
    modport timer (input load, duration, tempo, output expire);
endinterface

/* logic/music_regs.sv */
`timescale 1ns/1ps

module music_regs (
    input  logic                            clk_out,
    input  logic                            rst,
    input  logic [music_pkg::AXI_ADDR_W-1:0] awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [music_pkg::AXI_DATA_W-1:0] wdata,
    input  logic                            wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  logic                            bready,
    input  logic [music_pkg::AXI_ADDR_W-1:0] araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [music_pkg::AXI_DATA_W-1:0] rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  logic                            rready,
    player_ctrl_if.regs                     ctrl
);

    logic                            wr_accept;
    logic                            rd_accept;
    logic                            wr_hit;
    logic                            rd_hit;
    logic [music_pkg::AXI_DATA_W-1:0] rd_data;

    // Address and data taken together, one outstanding response per channel
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign rd_accept = arvalid && !rvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;
    assign arready   = rd_accept;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (music_pkg::reg_addr_t'(awaddr))
            music_pkg::REG_CTRL, music_pkg::REG_TEMPO,
            music_pkg::REG_STATUS, music_pkg::REG_NOTE: wr_hit = 1'b1;
            default:                                    wr_hit = 1'b0;
        endcase
    end

    always_comb begin
        rd_data = '0;
        rd_hit  = 1'b1;
        case (music_pkg::reg_addr_t'(araddr))
            music_pkg::REG_CTRL:   rd_data[2] = ctrl.loop;  // Start and stop read as zero
            music_pkg::REG_TEMPO:  rd_data[music_pkg::TEMPO_W-1:0] = ctrl.tempo;
            music_pkg::REG_STATUS: begin
                rd_data[0]    = ctrl.playing;
                rd_data[13:8] = ctrl.index;
            end
            music_pkg::REG_NOTE:   rd_data[music_pkg::NOTE_W-1:0] = ctrl.note;
            default:               rd_hit = 1'b0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registers and handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_out) begin
        if (rst) begin
            bvalid     <= 1'b0;
            rvalid     <= 1'b0;
            ctrl.start <= 1'b0;
            ctrl.stop  <= 1'b0;
            ctrl.loop  <= 1'b0;
            ctrl.tempo <= music_pkg::TEMPO_RESET;
        end else begin
            ctrl.start <= 1'b0;
            ctrl.stop  <= 1'b0;

            if (wr_accept) begin
                bvalid <= 1'b1;
                case (music_pkg::reg_addr_t'(awaddr))
                    music_pkg::REG_CTRL: begin
                        ctrl.start <= wdata[0];
                        ctrl.stop  <= wdata[1];
                        ctrl.loop  <= wdata[2];
                    end
                    music_pkg::REG_TEMPO: ctrl.tempo <= wdata[music_pkg::TEMPO_W-1:0];
                    default: ;  // Status and note are read-only
                endcase
            end else if (bready) begin
                bvalid <= 1'b0;
            end

            if (rd_accept) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Response payload, held while valid is high
    always_ff @(posedge clk_out) begin
        if (wr_accept) begin
            bresp <= wr_hit ? music_pkg::RESP_OKAY : music_pkg::RESP_SLVERR;
        end
        if (rd_accept) begin
            rdata <= rd_data;
            rresp <= rd_hit ? music_pkg::RESP_OKAY : music_pkg::RESP_SLVERR;
        end
    end

endmodule

/* logic/song_sequencer.sv */
`timescale 1ns/1ps

module song_sequencer (
    input  logic                           clk_out,
    input  logic                           rst,
    player_ctrl_if.seq                     ctrl,
    note_timer_if.seq                      tmr,
    output logic [music_pkg::IDX_W-1:0]     rom_addr,
    input  logic [music_pkg::NOTE_W-1:0]    rom_note,
    input  logic [music_pkg::DUR_W-1:0]     rom_duration,
    output logic [music_pkg::NOTE_W-1:0]    tone_note,
    output logic                           tone_enable
);

    music_pkg::player_state_t     state;
    logic [music_pkg::IDX_W-1:0]  index;
    logic [music_pkg::IDX_W-1:0]  idx_next;
    logic                        last;

    assign last     = index == music_pkg::IDX_W'(music_pkg::SONG_LEN - 1);
    assign idx_next = last ? '0 : index + 1'b1;

    // Look one entry ahead on expiry so the table word is ready in ST_FETCH
    assign rom_addr = (state == music_pkg::ST_PLAY && tmr.expire) ? idx_next : index;

    assign tmr.load     = state == music_pkg::ST_FETCH;
    assign tmr.duration = rom_duration;
    assign tmr.tempo    = ctrl.tempo;

    assign ctrl.playing = state != music_pkg::ST_IDLE;
    assign ctrl.index   = index;
    assign ctrl.note    = tone_note;

    always_ff @(posedge clk_out) begin
        if (rst) begin
            state       <= music_pkg::ST_IDLE;
            index       <= '0;
            tone_note   <= '0;
            tone_enable <= 1'b0;
        end else if (ctrl.stop) begin
            state       <= music_pkg::ST_IDLE;
            index       <= '0;
            tone_enable <= 1'b0;
        end else begin
            case (state)
                music_pkg::ST_IDLE: if (ctrl.start) state <= music_pkg::ST_FETCH;
                music_pkg::ST_FETCH: begin
                    state       <= music_pkg::ST_PLAY;
                    tone_note   <= rom_note;
                    tone_enable <= 1'b1;
                end
                music_pkg::ST_PLAY: begin
                    if (tmr.expire) begin
                        index <= idx_next;
                        if (last && !ctrl.loop) begin
                            state       <= music_pkg::ST_IDLE;  // End of song
                            tone_enable <= 1'b0;
                        end else begin
                            state <= music_pkg::ST_FETCH;
                        end
                    end
                end
                default: state <= music_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

/* logic/step_timer.sv */
`timescale 1ns/1ps

module step_timer (
    input  logic         clk_out,
    input  logic         rst,
    note_timer_if.timer  tmr
);

    logic [music_pkg::TEMPO_W-1:0] tempo_q;
    logic [music_pkg::TEMPO_W-1:0] cyc;
    logic [music_pkg::DUR_W-1:0]   dur_q;
    logic [music_pkg::DUR_W-1:0]   step;
    logic                         running;
    logic                         step_done;

    assign step_done  = cyc == tempo_q - 1'b1;
    assign tmr.expire = running && step_done && step == dur_q - 1'b1;

    always_ff @(posedge clk_out) begin
        if (rst) begin
            running <= 1'b0;
            cyc     <= '0;
            step    <= '0;
        end else if (tmr.load) begin
            running <= 1'b1;
            cyc     <= '0;
            step    <= '0;
        end else if (running) begin
            if (step_done) begin
                cyc <= '0;
                if (tmr.expire) running <= 1'b0;
                else            step    <= step + 1'b1;
            end else begin
                cyc <= cyc + 1'b1;
            end
        end
    end

    // Note length captured at load
    always_ff @(posedge clk_out) begin
        if (tmr.load) begin
            tempo_q <= tmr.tempo;
            dur_q   <= tmr.duration;
        end
    end

endmodule

/* logic/song_rom.sv */
`timescale 1ns/1ps

module song_rom (
    input  logic                        clk_out,
    input  logic [music_pkg::IDX_W-1:0]  addr,
    output logic [music_pkg::NOTE_W-1:0] note,
    output logic [music_pkg::DUR_W-1:0]  duration
);

    // Am, G, F, G arpeggios, each chord four times
    logic [music_pkg::NOTE_W+music_pkg::DUR_W-1:0] mem [music_pkg::SONG_LEN];

    initial begin
        $readmemh("song.hex", mem);
    end

    always_ff @(posedge clk_out) begin
        {note, duration} <= mem[addr];  // Note high byte, steps low byte
    end

endmodule

/* logic/tone_gen.sv */
`timescale 1ns/1ps

module tone_gen (
    input  logic                        clk_out,
    input  logic                        rst,
    input  logic [music_pkg::NOTE_W-1:0] note,
    input  logic                        enable,
    output logic                        beep
);

    logic [3:0]                  pitch;   // Pitch class, 0 is C
    logic [4:0]                  octave;
    logic [music_pkg::PER_W-1:0]  half;
    logic [music_pkg::PER_W-1:0]  cnt;
    logic [music_pkg::NOTE_W-1:0] note_q;
    logic                        active;

    assign pitch  = 4'(note % 8'd12);
    assign octave = 5'(note / 8'd12);
    assign half   = music_pkg::PITCH_HALF[pitch] >> octave;

    // Rests and very high notes stay silent
    assign active = enable && note != '0 && half != '0;

    always_ff @(posedge clk_out) begin
        if (rst) begin
            cnt    <= '0;
            note_q <= '0;
            beep   <= 1'b0;
        end else begin
            note_q <= note;
            if (!active || note != note_q) begin
                cnt  <= '0;  // New note restarts the period
                beep <= 1'b0;
            end else if (cnt == half - 1'b1) begin
                cnt  <= '0;
                beep <= ~beep;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

/* logic/music_player.sv */
`timescale 1ns/1ps

module music_player (
    input  logic                            clk_out,
    input  logic                            rst,
    input  logic [music_pkg::AXI_ADDR_W-1:0] awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [music_pkg::AXI_DATA_W-1:0] wdata,
    input  logic                            wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  logic                            bready,
    input  logic [music_pkg::AXI_ADDR_W-1:0] araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [music_pkg::AXI_DATA_W-1:0] rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  logic                            rready,
    output logic                            beep
);

    logic [music_pkg::IDX_W-1:0]  rom_addr;
    logic [music_pkg::NOTE_W-1:0] rom_note;
    logic [music_pkg::DUR_W-1:0]  rom_duration;
    logic [music_pkg::NOTE_W-1:0] tone_note;
    logic                        tone_enable;

    player_ctrl_if ctrl_if ();
    note_timer_if  tmr_if ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    music_regs i_music_regs (
        .clk_out (clk_out),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .ctrl    (ctrl_if)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Playback path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    song_sequencer i_song_sequencer (
        .clk_out      (clk_out),
        .rst          (rst),
        .ctrl         (ctrl_if),
        .tmr          (tmr_if),
        .rom_addr     (rom_addr),
        .rom_note     (rom_note),
        .rom_duration (rom_duration),
        .tone_note    (tone_note),
        .tone_enable  (tone_enable)
    );

    step_timer i_step_timer (
        .clk_out (clk_out),
        .rst     (rst),
        .tmr     (tmr_if)
    );

    song_rom i_song_rom (
        .clk_out  (clk_out),
        .addr     (rom_addr),
        .note     (rom_note),
        .duration (rom_duration)
    );

    tone_gen i_tone_gen (
        .clk_out (clk_out),
        .rst     (rst),
        .note    (tone_note),
        .enable  (tone_enable),
        .beep    (beep)
    );

endmodule

/* tb/music_player_chk.sv */
`timescale 1ns/1ps

module music_player_chk (
    input logic                            clk_out,
    input logic                            rst,
    input logic                            bvalid,
    input logic                            bready,
    input logic                            rvalid,
    input logic                            rready,
    input logic [music_pkg::AXI_DATA_W-1:0] rdata,
    input logic                            playing,
    input logic                            beep
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI4-Lite responses
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_bvalid_hold: assert property (@(posedge clk_out) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    a_rvalid_hold: assert property (@(posedge clk_out) disable iff (rst)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    a_rdata_stable: assert property (@(posedge clk_out) disable iff (rst)
        rvalid && !rready |=> $stable(rdata))
        else $error("rdata changed while waiting for rready");

    // Tone output settles one cycle after the sequencer goes idle
    a_beep_idle: assert property (@(posedge clk_out) disable iff (rst)
        !playing |=> !beep)
        else $error("beep high while the sequencer is idle");

endmodule

bind music_player music_player_chk i_music_player_chk (
    .clk_out (clk_out),
    .rst     (rst),
    .bvalid  (bvalid),
    .bready  (bready),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .playing (ctrl_if.playing),
    .beep    (beep)
);

/* tb/music_player_tb.sv */
`timescale 1ns/1ps

module music_player_tb;

    localparam int TEST_TEMPO = 8;  // Cycles per step during playback

    logic                            clk_out;
    logic                            rst;
    logic [music_pkg::AXI_ADDR_W-1:0] awaddr;
    logic                            awvalid;
    logic                            awready;
    logic [music_pkg::AXI_DATA_W-1:0] wdata;
    logic                            wvalid;
    logic                            wready;
    logic [1:0]                      bresp;
    logic                            bvalid;
    logic                            bready;
    logic [music_pkg::AXI_ADDR_W-1:0] araddr;
    logic                            arvalid;
    logic                            arready;
    logic [music_pkg::AXI_DATA_W-1:0] rdata;
    logic [1:0]                      rresp;
    logic                            rvalid;
    logic                            rready;
    logic                            beep;

    logic [15:0] song_mem [music_pkg::SONG_LEN];
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    int          status_snap = -1;  // Index seen in the last status read, -1 when idle
    bit          track_on = 1'b0;
    int          pitch_checks = 0;
    int          duration_checks = 0;

    // Edge tracking state of the comparing process
    logic beep_q = 1'b0;
    bit   edge_valid = 1'b0;
    int   edge_cyc = 0;
    int   edge_snap = -1;
    bit   pend_valid = 1'b0;
    int   pend_len = 0;
    int   pend_snap = -1;
    int   rise_snap = -1;
    int   rise_cyc = 0;

    music_player i_music_player (
        .clk_out (clk_out),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .beep    (beep)
    );

    initial begin
        clk_out = 1'b0;
        forever #4 clk_out = ~clk_out;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_value(input string what, input int got, input int exp);
        check_count = check_count + 1;
        if (got != exp) begin
            error_count = error_count + 1;
            $display("** Error at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    function automatic int song_note(input int idx);
        return int'(song_mem[idx][15:8]);
    endfunction

    function automatic int song_dur(input int idx);
        return int'(song_mem[idx][7:0]);
    endfunction

    // Half-period in cycles, octave shift applied to the C-based table
    function automatic int exp_half_period(input int note);
        int half;
        if (note == 0) begin
            return 0;
        end
        half = int'(music_pkg::PITCH_HALF[note % 12]);
        return half >> (note / 12);
    endfunction

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data, output int resp);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(posedge clk_out);
        while (!awready) @(posedge clk_out);
        check_value("wready with awready", int'(wready), 1);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        @(posedge clk_out);
        while (!bvalid) @(posedge clk_out);
        resp = int'(bresp);
        #1;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data, output int resp);
        araddr  = addr;
        arvalid = 1'b1;
        @(posedge clk_out);
        while (!arready) @(posedge clk_out);
        #1;
        arvalid = 1'b0;
        rready  = 1'b1;
        @(posedge clk_out);
        while (!rvalid) @(posedge clk_out);
        data = rdata;
        resp = int'(rresp);
        #1;
        rready = 1'b0;
    endtask

    // Index must only ever step to the next table entry
    task automatic poll_status(output int snap);
        logic [31:0] data;
        int          resp;
        axi_read(music_pkg::REG_STATUS, data, resp);
        snap = data[0] ? int'(data[13:8]) : -1;
        if (snap >= 0 && status_snap >= 0 && snap != status_snap) begin
            check_value("status index order", snap, (status_snap + 1) % music_pkg::SONG_LEN);
        end
        status_snap = snap;
    endtask

    task automatic hold_beep_low(input int cycles);
        repeat (cycles) begin
            @(negedge clk_out);
            check_value("beep held low", int'(beep), 0);
        end
        @(posedge clk_out);
        #1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Comparing process, beep edges at the falling clock
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk_out) begin
        if (!track_on) begin
            edge_valid = 1'b0;
            pend_valid = 1'b0;
            rise_snap  = -1;
        end else if (beep != beep_q) begin
            // An interval counts once the next edge shows it lay inside one entry
            if (pend_valid && pend_snap == status_snap) begin
                pitch_checks = pitch_checks + 1;
                check_value("beep half period", pend_len,
                            exp_half_period(song_note(pend_snap)));
            end
            pend_valid = edge_valid && edge_snap == status_snap && status_snap >= 0;
            pend_len   = cycle_cnt - edge_cyc;
            pend_snap  = status_snap;
            edge_valid = 1'b1;
            edge_cyc   = cycle_cnt;
            edge_snap  = status_snap;
            if (beep && status_snap >= 0 && status_snap != rise_snap) begin
                if (rise_snap >= 0 && status_snap == (rise_snap + 1) % music_pkg::SONG_LEN) begin
                    duration_checks = duration_checks + 1;
                    check_value("entry length in cycles",
                                cycle_cnt - rise_cyc - exp_half_period(song_note(status_snap))
                                + exp_half_period(song_note(rise_snap)),
                                song_dur(rise_snap) * TEST_TEMPO + 1);
                end
                rise_snap = status_snap;  // First toggle of a new entry
                rise_cyc  = cycle_cnt;
            end
        end
        beep_q = beep;
    end

    initial begin : watchdog
        forever begin
            @(posedge clk_out);
            cycle_cnt = cycle_cnt + 1;
            if (cycle_limit > 0 && cycle_cnt >= cycle_limit) break;
        end
        $display("Timeout: the simulation did not finish within %0d cycles", cycle_limit);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [31:0] data;
        int          resp;
        int          snap;
        int          prev;
        bit          wrapped;
        int          song_cycles;

        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;

        $readmemh("song.hex", song_mem);
        song_cycles = 0;
        for (int i = 0; i < music_pkg::SONG_LEN; i++) begin
            song_cycles = song_cycles + song_dur(i) * TEST_TEMPO + 1;
        end
        cycle_limit = 2 * song_cycles + 2000;

        repeat (4) @(posedge clk_out);
        #1;
        rst = 1'b0;

        // Register access
        axi_read(music_pkg::REG_TEMPO, data, resp);
        check_value("tempo after reset", int'(data), int'(music_pkg::TEMPO_RESET));
        check_value("tempo read resp", resp, 0);
        axi_write(music_pkg::REG_TEMPO, TEST_TEMPO, resp);
        check_value("tempo write resp", resp, 0);
        axi_read(music_pkg::REG_TEMPO, data, resp);
        check_value("tempo readback", int'(data), TEST_TEMPO);
        axi_write(music_pkg::REG_CTRL, 32'h4, resp);
        check_value("ctrl write resp", resp, 0);
        axi_read(music_pkg::REG_CTRL, data, resp);
        check_value("loop bit readback", int'(data), 4);
        axi_read(music_pkg::REG_STATUS, data, resp);
        check_value("status after reset", int'(data), 0);
        axi_read(music_pkg::REG_NOTE, data, resp);
        check_value("note after reset", int'(data), 0);
        check_value("note read resp", resp, 0);
        axi_write(4'h2, 32'h1, resp);
        check_value("unmapped write resp", resp, 2);
        axi_read(4'hE, data, resp);
        check_value("unmapped read resp", resp, 2);

        // Looped play until the index wraps and reaches entry 2 again
        status_snap = -1;
        track_on    = 1'b1;
        axi_write(music_pkg::REG_CTRL, 32'h5, resp);
        wrapped = 1'b0;
        prev    = -1;
        snap    = -1;
        while (!(wrapped && snap == 2)) begin
            poll_status(snap);
            if (snap < 0 && prev >= 0) begin
                check_value("playing with loop set", 0, 1);
                break;
            end
            if (prev == music_pkg::SONG_LEN - 1 && snap == 0) wrapped = 1'b1;
            prev = snap;
        end

        // Stop in the middle of the song
        track_on = 1'b0;
        axi_write(music_pkg::REG_CTRL, 32'h2, resp);
        poll_status(snap);
        check_value("playing after stop", snap, -1);
        hold_beep_low(40);

        // Restart without loop, play to the end
        status_snap = -1;
        track_on    = 1'b1;
        axi_write(music_pkg::REG_CTRL, 32'h1, resp);
        snap = -1;
        while (snap < 0) poll_status(snap);
        check_value("first index after restart", snap, 0);
        prev = snap;
        while (snap >= 0) begin
            prev = snap;
            poll_status(snap);
        end
        check_value("last entry before idle", prev, music_pkg::SONG_LEN - 1);
        track_on = 1'b0;
        axi_read(music_pkg::REG_STATUS, data, resp);
        check_value("status at end of song", int'(data), 0);
        hold_beep_low(40);

        check_value("pitch checks done", int'(pitch_checks > 0), 1);
        check_value("duration checks done", int'(duration_checks > 0), 1);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* song.hex */
// Note number in the high byte, duration in steps in the low byte
// Am: A3 C4 E4, G: G3 B3 D4, F: F3 A3 C4, each arpeggio played four times
3930
3C30
4030
3930
3C30
4030
3930
3C30
4030
3930
3C30
4030
3730
3B30
3E30
3730
3B30
3E30
3730
3B30
3E30
3730
3B30
3E30
3530
3930
3C30
3530
3930
3C30
3530
3930
3C30
3530
3930
3C30
3730
3B30
3E30
3730
3B30
3E30
3730
3B30
3E30
3730
3B30
3E30

/* music_player.f */
logic/music_pkg.sv
logic/player_ctrl_if.sv
logic/note_timer_if.sv
logic/music_regs.sv
logic/song_sequencer.sv
logic/step_timer.sv
logic/song_rom.sv
logic/tone_gen.sv
logic/music_player.sv
tb/music_player_chk.sv
tb/music_player_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module music_player_tb \
    -f music_player.f -Mdir obj_dir > sim.log 2>&1 \
    && ./obj_dir/Vmusic_player_tb >> sim.log 2>&1 \
    || echo "SIMULATION FAILED" >> sim.log
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0
